// File: project.f
+incdir+bench
design/clause_pkg.sv
design/bcp_ctrl_pkg.sv
design/clause_cell.sv
design/clause_array.sv
design/var_table.sv
design/imply_counter.sv
design/prop_fsm.sv
design/bcp_top.sv
bench/bcp_tb.sv

// File: Bender.yml
package:
  name: bcp

sources:
  - design/clause_pkg.sv
  - design/bcp_ctrl_pkg.sv
  - design/clause_cell.sv
  - design/clause_array.sv
  - design/var_table.sv
  - design/imply_counter.sv
  - design/prop_fsm.sv
  - design/bcp_top.sv
  - target: simulation
    include_dirs:
      - bench
    files:
      - bench/bcp_tb.sv

// File: bench/bcp_ref.svh
`ifndef BCP_REF_SVH
`define BCP_REF_SVH

// Status of one clause under an assignment.
function automatic void clause_status(input cls_t cls, input asg_t asg, output bit sat,
        output bit confl, output bit unit, output int uvar, output val_t uval);
    int n_lit;
    int n_free;
    bit any_true;
    n_lit    = 0;
    n_free   = 0;
    any_true = 1'b0;
    uvar     = 0;
    uval     = VAL_FREE;
    for (int v = 0; v < NUM_VARS; v++) begin
        if (cls[v] != LIT_NONE) begin
            n_lit++;
            if (asg[v] == VAL_FREE) begin
                n_free++;
                uvar = v;
                uval = (cls[v] == LIT_POS) ? VAL_TRUE : VAL_FALSE;  // Makes the literal true.
            end else if (cls[v] == LIT_POS && asg[v] == VAL_TRUE) begin
                any_true = 1'b1;
            end else if (cls[v] == LIT_NEG && asg[v] == VAL_FALSE) begin
                any_true = 1'b1;
            end
        end
    end
    sat   = any_true || (n_lit == 0);
    confl = (n_lit > 0) && !any_true && (n_free == 0);
    unit  = !any_true && (n_free == 1);
endfunction

// Rounds run to the end on the bench copy of the clauses.
function automatic void predict_result(input asg_t start, output res_code_t code,
        output asg_t fin, output int cnt);
    bit   sat;
    bit   confl;
    bit   unit;
    bit   all_sat;
    bit   any_confl;
    bit   found;
    bit   done;
    int   uvar;
    int   ivar;
    val_t uval;
    val_t ival;
    fin  = start;
    cnt  = 0;
    done = 1'b0;
    code = RES_STUCK;
    while (!done) begin
        all_sat   = 1'b1;
        any_confl = 1'b0;
        found     = 1'b0;
        ivar      = 0;
        ival      = VAL_FREE;
        for (int c = 0; c < NUM_CLAUSES; c++) begin
            clause_status(model_cls[c], fin, sat, confl, unit, uvar, uval);
            all_sat   = all_sat && sat;
            any_confl = any_confl || confl;
            if (unit && !found) begin
                found = 1'b1;  // Lowest index wins.
                ivar  = uvar;
                ival  = uval;
            end
        end
        done = 1'b1;
        if (any_confl) begin
            code = RES_CONFLICT;
        end else if (all_sat) begin
            code = RES_SAT;
        end else if (found && cnt == MAX_IMPLY) begin
            code = RES_LIMIT;
        end else if (found) begin
            fin[ivar] = ival;
            cnt++;
            done = 1'b0;
        end else begin
            code = RES_STUCK;
        end
    end
endfunction

`endif

// File: bench/bcp_tb.sv
`timescale 1ns/1ps

module bcp_tb
    import clause_pkg::*;
    import bcp_ctrl_pkg::*;
();

    localparam int NUM_VARS    = 8;
    localparam int NUM_CLAUSES = 8;
    localparam int MAX_IMPLY   = 6;
    localparam int VAR_W       = $clog2(NUM_VARS);
    localparam int CLS_W       = $clog2(NUM_CLAUSES);
    localparam int CNT_W       = $clog2(MAX_IMPLY + 1);
    localparam int NUM_TESTS   = 47;  // Seven directed, forty random.

    typedef lit_t [NUM_VARS-1:0] cls_t;
    typedef val_t [NUM_VARS-1:0] asg_t;

    logic             clk;
    logic             rst;
    logic             clause_wr_i;
    logic [CLS_W-1:0] clause_idx_i;
    cls_t             clause_lits_i;
    logic             var_wr_i;
    logic [VAR_W-1:0] var_idx_i;
    val_t             var_val_i;
    logic             start_valid_i;
    logic             start_ready_o;
    logic             res_ready_i;
    logic             res_valid_o;
    res_code_t        res_code_o;
    asg_t             res_assign_o;
    logic [CNT_W-1:0] res_count_o;

    cls_t             model_cls [NUM_CLAUSES];
    asg_t             model_asg;
    res_code_t        exp_code;
    asg_t             exp_asg;
    logic [CNT_W-1:0] exp_cnt;
    res_code_t        prev_code;
    asg_t             prev_asg;
    logic [CNT_W-1:0] prev_cnt;
    int               value_errs    = 0;
    int               other_errs    = 0;
    int               results_taken = 0;
    int               seed          = 32'h3a2a7512;

    `include "bcp_ref.svh"

    bcp_top #(
        .NUM_VARS    (NUM_VARS),
        .NUM_CLAUSES (NUM_CLAUSES),
        .MAX_IMPLY   (MAX_IMPLY)
    ) u_dut (
        .clk           (clk),
        .rst           (rst),
        .clause_wr_i   (clause_wr_i),
        .clause_idx_i  (clause_idx_i),
        .clause_lits_i (clause_lits_i),
        .var_wr_i      (var_wr_i),
        .var_idx_i     (var_idx_i),
        .var_val_i     (var_val_i),
        .start_valid_i (start_valid_i),
        .start_ready_o (start_ready_o),
        .res_ready_i   (res_ready_i),
        .res_valid_o   (res_valid_o),
        .res_code_o    (res_code_o),
        .res_assign_o  (res_assign_o),
        .res_count_o   (res_count_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ========================================
    // Result checks
    // ========================================

    always @(posedge clk) begin
        prev_code <= res_code_o;
        prev_asg  <= res_assign_o;
        prev_cnt  <= res_count_o;
    end

    task automatic report_mismatch(input string name, input logic [63:0] exp_v,
            input logic [63:0] act_v);
        $display("** Error at %0t: %s expected %0h, got %0h", $time, name, exp_v, act_v);
        value_errs++;
    endtask

    code_ok: assert property (@(posedge clk) disable iff (!rst)
        (res_valid_o && res_ready_i) |-> (res_code_o == exp_code))
        else report_mismatch("res_code_o", exp_code, $sampled(res_code_o));
    assign_ok: assert property (@(posedge clk) disable iff (!rst)
        (res_valid_o && res_ready_i) |-> (res_assign_o == exp_asg))
        else report_mismatch("res_assign_o", exp_asg, $sampled(res_assign_o));
    count_ok: assert property (@(posedge clk) disable iff (!rst)
        (res_valid_o && res_ready_i) |-> (res_count_o == exp_cnt))
        else report_mismatch("res_count_o", exp_cnt, $sampled(res_count_o));

    // Held outputs under back-pressure.
    code_held: assert property (@(posedge clk) disable iff (!rst)
        (res_valid_o && !res_ready_i) |=> (res_code_o == prev_code))
        else report_mismatch("res_code_o", $sampled(prev_code), $sampled(res_code_o));
    assign_held: assert property (@(posedge clk) disable iff (!rst)
        (res_valid_o && !res_ready_i) |=> (res_assign_o == prev_asg))
        else report_mismatch("res_assign_o", $sampled(prev_asg), $sampled(res_assign_o));
    count_held: assert property (@(posedge clk) disable iff (!rst)
        (res_valid_o && !res_ready_i) |=> (res_count_o == prev_cnt))
        else report_mismatch("res_count_o", $sampled(prev_cnt), $sampled(res_count_o));

    // Busy from the accepted start until the result is taken.
    busy_after_start: assert property (@(posedge clk) disable iff (!rst)
        (start_valid_i && start_ready_o) |=> !start_ready_o)
        else report_mismatch("start_ready_o", 1'b0, $sampled(start_ready_o));
    idle_after_take: assert property (@(posedge clk) disable iff (!rst)
        (res_valid_o && res_ready_i) |=> start_ready_o)
        else report_mismatch("start_ready_o", 1'b1, $sampled(start_ready_o));

    // ========================================
    // Stimulus helpers
    // ========================================

    function automatic void clear_model();
        for (int c = 0; c < NUM_CLAUSES; c++) begin
            for (int v = 0; v < NUM_VARS; v++) begin
                model_cls[c][v] = LIT_NONE;
            end
        end
        for (int v = 0; v < NUM_VARS; v++) begin
            model_asg[v] = VAL_FREE;
        end
    endfunction

    function automatic void add_bin(input int c, input int va, input lit_t la,
            input int vb, input lit_t lb);
        model_cls[c][va] = la;
        model_cls[c][vb] = lb;
    endfunction

    // Clause i is (not x_i or x_i+1), with x0 set.
    function automatic void build_chain(input int len);
        for (int i = 0; i < len; i++) begin
            add_bin(i, i, LIT_NEG, i + 1, LIT_POS);
        end
        model_asg[0] = VAL_TRUE;
    endfunction

    task automatic random_model();
        int r;
        clear_model();
        for (int c = 0; c < NUM_CLAUSES; c++) begin
            for (int v = 0; v < NUM_VARS; v++) begin
                r = $random(seed);
                if (r[2:0] == 3'd0) model_cls[c][v] = LIT_POS;
                else if (r[2:0] == 3'd1) model_cls[c][v] = LIT_NEG;
            end
        end
        for (int v = 0; v < NUM_VARS; v++) begin
            r = $random(seed);
            if (r[4:2] == 3'd0) model_asg[v] = VAL_TRUE;
            else if (r[4:2] == 3'd1) model_asg[v] = VAL_FALSE;
        end
    endtask

    task automatic load_model(input bit with_clauses);
        if (with_clauses) begin
            for (int c = 0; c < NUM_CLAUSES; c++) begin
                @(negedge clk);
                clause_wr_i   = 1'b1;
                clause_idx_i  = CLS_W'(c);
                clause_lits_i = model_cls[c];
            end
        end
        for (int v = 0; v < NUM_VARS; v++) begin
            @(negedge clk);
            clause_wr_i = 1'b0;
            var_wr_i    = 1'b1;
            var_idx_i   = VAR_W'(v);
            var_val_i   = model_asg[v];
        end
        @(negedge clk);
        var_wr_i = 1'b0;
    endtask

    task automatic run_case(input int hold_max, input bit inject);
        int   waited;
        int   hold;
        int   exp_n;
        cls_t stray;
        predict_result(model_asg, exp_code, exp_asg, exp_n);
        exp_cnt = CNT_W'(exp_n);
        for (int v = 0; v < NUM_VARS; v++) begin
            stray[v] = (v == 0) ? LIT_NEG : LIT_NONE;  // Would conflict at once.
        end
        @(negedge clk);
        start_valid_i = 1'b1;
        @(negedge clk);
        start_valid_i = 1'b0;
        if (inject) begin
            clause_wr_i   = 1'b1;  // Engine busy, must be dropped.
            clause_idx_i  = CLS_W'(NUM_CLAUSES - 1);
            clause_lits_i = stray;
            @(negedge clk);
            clause_wr_i = 1'b0;
        end
        waited = 0;
        while (!res_valid_o && waited < MAX_IMPLY + 4) begin
            @(negedge clk);
            waited++;
        end
        if (!res_valid_o) begin
            $display("No result from the engine within %0d cycles of the start", waited);
            other_errs++;
        end else begin
            hold = (hold_max > 0) ? ($unsigned($random(seed)) % (hold_max + 1)) : 0;
            repeat (hold) @(negedge clk);
            res_ready_i = 1'b1;
            @(negedge clk);
            res_ready_i = 1'b0;
            results_taken++;
        end
    endtask

    // ========================================
    // Test sequence
    // ========================================

    initial begin
        rst           = 1'b0;
        clause_wr_i   = 1'b0;
        clause_idx_i  = '0;
        clause_lits_i = {NUM_VARS{LIT_NONE}};
        var_wr_i      = 1'b0;
        var_idx_i     = '0;
        var_val_i     = VAL_FREE;
        start_valid_i = 1'b0;
        res_ready_i   = 1'b0;
        repeat (3) @(negedge clk);
        rst = 1'b1;

        clear_model();
        build_chain(5);  // Five implications, then satisfied.
        load_model(1'b1);
        run_case(0, 1'b0);

        clear_model();
        add_bin(0, 0, LIT_NEG, 1, LIT_POS);
        add_bin(1, 1, LIT_NEG, 2, LIT_POS);
        add_bin(2, 2, LIT_NEG, 0, LIT_NEG);
        model_asg[0] = VAL_TRUE;
        load_model(1'b1);
        run_case(0, 1'b0);

        // Clause 0 must fire before clause 5 in the second round.
        clear_model();
        add_bin(0, 1, LIT_NEG, 2, LIT_NEG);
        add_bin(2, 0, LIT_NEG, 1, LIT_POS);
        add_bin(5, 0, LIT_NEG, 2, LIT_POS);
        model_asg[0] = VAL_TRUE;
        load_model(1'b1);
        run_case(0, 1'b0);

        clear_model();
        add_bin(0, 3, LIT_NEG, 4, LIT_POS);
        add_bin(1, 0, LIT_POS, 1, LIT_POS);
        model_cls[1][2] = LIT_POS;
        model_asg[3] = VAL_TRUE;
        load_model(1'b1);
        run_case(0, 1'b0);

        clear_model();
        build_chain(7);
        load_model(1'b1);
        run_case(0, 1'b0);

        clear_model();
        build_chain(5);
        load_model(1'b1);
        run_case(5, 1'b1);
        load_model(1'b0);  // Clauses kept from before.
        run_case(5, 1'b0);

        repeat (40) begin
            random_model();
            load_model(1'b1);
            run_case(2, 1'b0);
        end

        if (results_taken != NUM_TESTS) begin
            $display("Only %0d of %0d results were taken", results_taken, NUM_TESTS);
            other_errs++;
        end
        $display("Errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    initial begin
        repeat (NUM_TESTS * (NUM_VARS + 20)) @(posedge clk);
        $display("Watchdog expired before the test sequence finished");
        $display("Errors: %0d value mismatches, %0d other failures", value_errs, other_errs + 1);
        $display("test failed");
        $finish;
    end

endmodule

// File: design/bcp_top.sv
`timescale 1ns/1ps

module bcp_top
    import clause_pkg::*;
    import bcp_ctrl_pkg::*;
#(
    parameter int NUM_VARS    = 8,
    parameter int NUM_CLAUSES = 8,
    parameter int MAX_IMPLY   = 8,
    localparam int VAR_W = (NUM_VARS > 1) ? $clog2(NUM_VARS) : 1,
    localparam int CLS_W = (NUM_CLAUSES > 1) ? $clog2(NUM_CLAUSES) : 1,
    localparam int CNT_W = (MAX_IMPLY > 0) ? $clog2(MAX_IMPLY + 1) : 1
) (
    input  logic                      clk,
    input  logic                      rst,
    // Host load.
    input  logic                      clause_wr_i,
    input  logic [CLS_W-1:0]          clause_idx_i,
    input  lit_t [NUM_VARS-1:0]       clause_lits_i,
    input  logic                      var_wr_i,
    input  logic [VAR_W-1:0]          var_idx_i,
    input  val_t                      var_val_i,
    // Start and result handshakes.
    input  logic                      start_valid_i,
    output logic                      start_ready_o,
    input  logic                      res_ready_i,
    output logic                      res_valid_o,
    output res_code_t                 res_code_o,
    output val_t [NUM_VARS-1:0]       res_assign_o,
    output logic [CNT_W-1:0]          res_count_o
);

    val_t [NUM_VARS-1:0] assign_w;
    logic                conflict;
    logic                all_sat;
    logic                imp_valid;
    logic [VAR_W-1:0]    imp_var;
    val_t                imp_val;
    logic                imp_apply;
    logic                cnt_clear;
    logic                at_limit;
    logic                clause_wr_g;
    logic                var_wr_g;

    // Host writes only land while idle.
    assign clause_wr_g = clause_wr_i && start_ready_o;
    assign var_wr_g    = var_wr_i && start_ready_o;

    clause_array #(
        .NUM_VARS    (NUM_VARS),
        .NUM_CLAUSES (NUM_CLAUSES)
    ) u_clause_array (
        .clk         (clk),
        .rst         (rst),
        .wr_i        (clause_wr_g),
        .idx_i       (clause_idx_i),
        .lits_i      (clause_lits_i),
        .assign_i    (assign_w),
        .conflict_o  (conflict),
        .all_sat_o   (all_sat),
        .imp_valid_o (imp_valid),
        .imp_var_o   (imp_var),
        .imp_val_o   (imp_val)
    );

    var_table #(
        .NUM_VARS (NUM_VARS)
    ) u_var_table (
        .clk         (clk),
        .rst         (rst),
        .wr_i        (var_wr_g),
        .idx_i       (var_idx_i),
        .val_i       (var_val_i),
        .imp_apply_i (imp_apply),
        .imp_var_i   (imp_var),
        .imp_val_i   (imp_val),
        .assign_o    (assign_w)
    );

    imply_counter #(
        .MAX_IMPLY (MAX_IMPLY)
    ) u_imply_counter (
        .clk        (clk),
        .rst        (rst),
        .clear_i    (cnt_clear),
        .inc_i      (imp_apply),
        .count_o    (res_count_o),
        .at_limit_o (at_limit)
    );

    prop_fsm u_prop_fsm (
        .clk           (clk),
        .rst           (rst),
        .start_valid_i (start_valid_i),
        .start_ready_o (start_ready_o),
        .res_ready_i   (res_ready_i),
        .res_valid_o   (res_valid_o),
        .res_code_o    (res_code_o),
        .conflict_i    (conflict),
        .all_sat_i     (all_sat),
        .imp_valid_i   (imp_valid),
        .at_limit_i    (at_limit),
        .imp_apply_o   (imp_apply),
        .cnt_clear_o   (cnt_clear)
    );

    assign res_assign_o = assign_w;  // Frozen while in DONE.

endmodule

// File: design/prop_fsm.sv
`timescale 1ns/1ps

module prop_fsm
    import bcp_ctrl_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      start_valid_i,
    output logic      start_ready_o,
    input  logic      res_ready_i,
    output logic      res_valid_o,
    output res_code_t res_code_o,
    input  logic      conflict_i,
    input  logic      all_sat_i,
    input  logic      imp_valid_i,
    input  logic      at_limit_i,
    output logic      imp_apply_o,
    output logic      cnt_clear_o
);

    typedef enum logic [1:0] {
        IDLE,
        EVAL,
        DONE
    } state_t;

    state_t    state_q;
    state_t    state_d;
    res_code_t round_code;
    logic      round_done;
    res_code_t code_q;

    // ========================================
    // Round rule
    // ========================================

    always_comb begin
        round_done = 1'b1;
        round_code = RES_STUCK;
        if (conflict_i) begin
            round_code = RES_CONFLICT;
        end else if (all_sat_i) begin
            round_code = RES_SAT;
        end else if (imp_valid_i && at_limit_i) begin
            round_code = RES_LIMIT;
        end else if (imp_valid_i) begin
            round_done = 1'b0;  // Apply and evaluate again.
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:    if (start_valid_i) state_d = EVAL;
            EVAL:    if (round_done) state_d = DONE;
            DONE:    if (res_ready_i) state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        if ((state_q == EVAL) && round_done) begin
            code_q <= round_code;  // Held through DONE.
        end
    end

    assign start_ready_o = (state_q == IDLE);
    assign res_valid_o   = (state_q == DONE);
    assign res_code_o    = code_q;
    assign cnt_clear_o   = start_valid_i && start_ready_o;
    assign imp_apply_o   = (state_q == EVAL) && !round_done;

endmodule

// File: design/imply_counter.sv
`timescale 1ns/1ps

module imply_counter #(
    parameter int MAX_IMPLY = 8,
    localparam int CNT_W = (MAX_IMPLY > 0) ? $clog2(MAX_IMPLY + 1) : 1
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             clear_i,
    input  logic             inc_i,
    output logic [CNT_W-1:0] count_o,
    output logic             at_limit_o
);

    logic [CNT_W-1:0] count_q;

    always_ff @(posedge clk) begin
        if (!rst || clear_i) begin
            count_q <= '0;
        end else if (inc_i && !at_limit_o) begin
            count_q <= count_q + CNT_W'(1);  // Never wraps past the limit.
        end
    end

    assign count_o    = count_q;
    assign at_limit_o = (count_q == CNT_W'(MAX_IMPLY));

endmodule

// File: design/var_table.sv
`timescale 1ns/1ps

module var_table
    import clause_pkg::*;
#(
    parameter int NUM_VARS = 8,
    localparam int VAR_W = (NUM_VARS > 1) ? $clog2(NUM_VARS) : 1
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      wr_i,
    input  logic [VAR_W-1:0]          idx_i,
    input  val_t                      val_i,
    input  logic                      imp_apply_i,
    input  logic [VAR_W-1:0]          imp_var_i,
    input  val_t                      imp_val_i,
    output val_t [NUM_VARS-1:0]       assign_o
);

    val_t [NUM_VARS-1:0] vals_q;

    logic             wr_en;
    logic [VAR_W-1:0] wr_idx;
    val_t             wr_val;

    // Host and implication share one port.
    assign wr_en  = wr_i || imp_apply_i;
    assign wr_idx = imp_apply_i ? imp_var_i : idx_i;
    assign wr_val = imp_apply_i ? imp_val_i : val_i;

    always_ff @(posedge clk) begin
        if (!rst) begin
            vals_q <= {NUM_VARS{VAL_FREE}};
        end else begin
            for (int v = 0; v < NUM_VARS; v++) begin
                if (wr_en && (wr_idx == VAR_W'(v))) begin
                    vals_q[v] <= wr_val;
                end
            end
        end
    end

    assign assign_o = vals_q;

endmodule

// File: design/clause_array.sv
`timescale 1ns/1ps

module clause_array
    import clause_pkg::*;
#(
    parameter int NUM_VARS    = 8,
    parameter int NUM_CLAUSES = 8,
    localparam int VAR_W = (NUM_VARS > 1) ? $clog2(NUM_VARS) : 1,
    localparam int CLS_W = (NUM_CLAUSES > 1) ? $clog2(NUM_CLAUSES) : 1
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      wr_i,
    input  logic [CLS_W-1:0]          idx_i,
    input  lit_t [NUM_VARS-1:0]       lits_i,
    input  val_t [NUM_VARS-1:0]       assign_i,
    output logic                      conflict_o,
    output logic                      all_sat_o,
    output logic                      imp_valid_o,
    output logic [VAR_W-1:0]          imp_var_o,
    output val_t                      imp_val_o
);

    logic [NUM_CLAUSES-1:0] cell_wr;
    logic [NUM_CLAUSES-1:0] cell_sat;
    logic [NUM_CLAUSES-1:0] cell_conflict;
    logic [NUM_CLAUSES-1:0] cell_unit;
    logic [VAR_W-1:0]       cell_var [NUM_CLAUSES];
    val_t                   cell_val [NUM_CLAUSES];

    for (genvar c = 0; c < NUM_CLAUSES; c++) begin : g_cell
        assign cell_wr[c] = wr_i && (idx_i == CLS_W'(c));  // Write decode.

        clause_cell #(
            .NUM_VARS (NUM_VARS)
        ) u_cell (
            .clk        (clk),
            .rst        (rst),
            .wr_i       (cell_wr[c]),
            .lits_i     (lits_i),
            .assign_i   (assign_i),
            .lits_o     (),
            .sat_o      (cell_sat[c]),
            .conflict_o (cell_conflict[c]),
            .unit_o     (cell_unit[c]),
            .imp_var_o  (cell_var[c]),
            .imp_val_o  (cell_val[c])
        );
    end

    // ========================================
    // Reduction
    // ========================================

    assign conflict_o  = |cell_conflict;
    assign all_sat_o   = &cell_sat;
    assign imp_valid_o = |cell_unit;

    // Walk downward so the lowest unit index is left standing.
    always_comb begin
        imp_var_o = '0;
        imp_val_o = VAL_FREE;
        for (int c = NUM_CLAUSES - 1; c >= 0; c--) begin
            if (cell_unit[c]) begin
                imp_var_o = cell_var[c];
                imp_val_o = cell_val[c];
            end
        end
    end

endmodule

// File: design/clause_cell.sv
`timescale 1ns/1ps

module clause_cell
    import clause_pkg::*;
#(
    parameter int NUM_VARS = 8,
    localparam int VAR_W = (NUM_VARS > 1) ? $clog2(NUM_VARS) : 1
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      wr_i,
    input  lit_t [NUM_VARS-1:0]       lits_i,
    input  val_t [NUM_VARS-1:0]       assign_i,
    output lit_t [NUM_VARS-1:0]       lits_o,
    output logic                      sat_o,
    output logic                      conflict_o,
    output logic                      unit_o,
    output logic [VAR_W-1:0]          imp_var_o,
    output val_t                      imp_val_o
);

    lit_t [NUM_VARS-1:0] lits_q;

    logic [1:0]       free_cnt;   // Saturates at two.
    logic             any_true;
    logic             any_lit;
    logic [VAR_W-1:0] free_idx;
    lit_t             free_lit;

    always_ff @(posedge clk) begin
        if (!rst) begin
            lits_q <= {NUM_VARS{LIT_NONE}};  // Empty clause.
        end else if (wr_i) begin
            lits_q <= lits_i;
        end
    end

    assign lits_o = lits_q;

    // ========================================
    // Clause evaluation
    // ========================================

    always_comb begin
        free_cnt = 2'd0;
        any_true = 1'b0;
        any_lit  = 1'b0;
        free_idx = '0;
        free_lit = LIT_NONE;
        for (int i = 0; i < NUM_VARS; i++) begin
            if (lits_q[i] != LIT_NONE) begin
                any_lit = 1'b1;
                if (assign_i[i] == VAL_FREE) begin
                    if (free_cnt != 2'd2) begin
                        free_cnt = free_cnt + 2'd1;
                    end
                    free_idx = VAR_W'(i);  // Only meaningful when unit.
                    free_lit = lits_q[i];
                end else if (lit_is_true(lits_q[i], assign_i[i])) begin
                    any_true = 1'b1;
                end
            end
        end
    end

    assign sat_o      = any_true || !any_lit;
    assign conflict_o = any_lit && !any_true && (free_cnt == 2'd0);
    assign unit_o     = !any_true && (free_cnt == 2'd1);
    assign imp_var_o  = free_idx;
    assign imp_val_o  = lit_to_val(free_lit);

endmodule

// File: design/bcp_ctrl_pkg.sv
package bcp_ctrl_pkg;

    // ========================================
    // Propagation result codes
    // ========================================

    typedef enum logic [1:0] {
        RES_SAT      = 2'd0,  // Every clause satisfied.
        RES_CONFLICT = 2'd1,  // Some clause all false.
        RES_STUCK    = 2'd2,  // No unit clause left.
        RES_LIMIT    = 2'd3   // Implication budget spent.
    } res_code_t;

endpackage

// File: design/clause_pkg.sv
package clause_pkg;

    // ========================================
    // Literal and value encodings
    // ========================================

    typedef enum logic [1:0] {
        LIT_NONE = 2'b00,  // Variable absent from clause.
        LIT_POS  = 2'b01,  // Plain variable.
        LIT_NEG  = 2'b10   // Negated variable.
    } lit_t;

    typedef enum logic [1:0] {
        VAL_FREE  = 2'b00,
        VAL_FALSE = 2'b01,
        VAL_TRUE  = 2'b10
    } val_t;

    // Literal holds under the given value.
    function automatic logic lit_is_true(lit_t lit, val_t val);
        return ((lit == LIT_POS) && (val == VAL_TRUE)) ||
               ((lit == LIT_NEG) && (val == VAL_FALSE));
    endfunction

    // Value that makes the literal true.
    function automatic val_t lit_to_val(lit_t lit);
        return (lit == LIT_NEG) ? VAL_FALSE : VAL_TRUE;
    endfunction

endpackage
